// File: cpuCore.f
source/cpuPkg.sv
source/cpuControl.sv
source/aluUnit.sv
source/registerFile.sv
source/programCounter.sv
source/busInterface.sv
source/cpuCore.sv
verification/busMemoryModel.sv
verification/cpuCoreTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the cpuCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f cpuCore.f --top-module cpuCoreTb -Mdir obj_dir -o cpuCoreSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/cpuCoreSim > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
if [ $runStatus -ne 0 ]; then
   echo "Simulator exited with status $runStatus"
   exit 1
fi
exit 0

// File: source/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
   input  logic                           Clock,
   input  logic                           nReset,
   input  cpuPkg::controlWord_t           Ctrl,
   input  logic [cpuPkg::DataWidth-1:0]   Instruction,
   input  logic [cpuPkg::DataWidth-1:0]   OperandA,
   input  logic [cpuPkg::DataWidth-1:0]   OperandB,
   input  logic                           CarryIn,
   output logic [cpuPkg::DataWidth-1:0]   Result,
   output logic [cpuPkg::DataWidth-1:0]   AluReg,
   output logic [3:0]                     Flags
);

   localparam int Dw = cpuPkg::DataWidth;

   logic [Dw-1:0] immValue;
   logic [Dw-1:0] operand2;
   logic [Dw-1:0] addend;
   logic [Dw:0]   sum;
   logic          carryBit;
   logic          subtract;

   assign immValue = (Ctrl.ImmSel == cpuPkg::ImmLong) ?
                     {{(Dw-8){1'b0}}, Instruction[7:0]} : {{(Dw-5){1'b0}}, Instruction[4:0]};
   assign operand2 = (Ctrl.Op2Sel == cpuPkg::Op2Imm) ? immValue : OperandB;
   assign subtract = (Ctrl.AluOp == cpuPkg::FnSub) || (Ctrl.AluOp == cpuPkg::FnSuc);
   assign addend   = subtract ? ~operand2 : operand2;  // Subtract as A + ~B + carry

   always_comb begin
      case (Ctrl.AluOp)
         cpuPkg::FnSub:                carryBit = 1'b1;
         cpuPkg::FnAdc, cpuPkg::FnSuc: carryBit = CarryIn;
         default:                      carryBit = 1'b0;
      endcase
      sum = {1'b0, OperandA} + {1'b0, addend} + {{Dw{1'b0}}, carryBit};
      case (Ctrl.AluOp)
         cpuPkg::FnAdd, cpuPkg::FnAdc, cpuPkg::FnSub, cpuPkg::FnSuc: Result = sum[Dw-1:0];
         cpuPkg::FnLoadLow:  Result = immValue;
         cpuPkg::FnLoadHigh: Result = {Instruction[7:0], OperandA[Dw-9:0]};
         cpuPkg::FnPass:     Result = OperandB;
         default:            Result = '0;
      endcase
   end

   assign Flags[cpuPkg::FlagC] = sum[Dw];  // Set means no borrow on subtract
   assign Flags[cpuPkg::FlagZ] = Result == '0;
   assign Flags[cpuPkg::FlagN] = Result[Dw-1];
   assign Flags[cpuPkg::FlagV] = (OperandA[Dw-1] == addend[Dw-1]) &&
                                 (sum[Dw-1] != OperandA[Dw-1]);

   // Holds memory address, then store data
   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         AluReg <= '0;
      else if (Ctrl.AluWe)
         AluReg <= Result;
   end

endmodule

// File: source/busInterface.sv
`timescale 1ns/10ps

module busInterface (
   input  logic                           Clock,
   input  logic                           nReset,
   input  cpuPkg::controlWord_t           Ctrl,
   input  cpuPkg::busStrobes_t            Strobes,
   input  logic [cpuPkg::DataWidth-1:0]   Pc,
   input  logic [cpuPkg::DataWidth-1:0]   AluReg,
   input  logic [cpuPkg::DataWidth-1:0]   BusIn,
   output logic [cpuPkg::DataWidth-1:0]   BusOut,
   output logic                           BusDrive,
   output logic                           Ale,
   output logic                           nMe,
   output logic                           nOe,
   output logic                           nWe,
   output logic [cpuPkg::DataWidth-1:0]   ReadData
);

   // Fetch address from PC, data address and store data from AluReg
   assign BusOut   = Ctrl.AddrFromPc ? Pc : AluReg;
   assign BusDrive = Strobes.BusDrive;
   assign Ale      = Strobes.Ale;
   assign nMe      = Strobes.nMe;
   assign nOe      = Strobes.nOe;
   assign nWe      = Strobes.nWe;

   // Sampled at the end of the second read cycle
   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         ReadData <= '0;
      else if (Strobes.Capture)
         ReadData <= BusIn;
   end

endmodule

// File: source/cpuControl.sv
`timescale 1ns/10ps

module cpuControl (
   input  logic                 Clock,
   input  logic                 nReset,
   input  logic [7:0]           OpcodeCond,
   input  logic [3:0]           Flags,
   output cpuPkg::controlWord_t Ctrl,
   output cpuPkg::busStrobes_t  Strobes,
   output logic                 CarryIn
);

   typedef enum logic [1:0] {Idle, Fetch, Execute} majorState_t;
   typedef enum logic [1:0] {Fet1, Fet2, Fet3, Fet4} fetchStep_t;
   typedef enum logic [2:0] {Exe1, Exe2, Exe3, Exe4, Exe5} executeStep_t;

   majorState_t          majorState;
   fetchStep_t           fetchStep;
   executeStep_t         executeStep;
   cpuPkg::opcode_t      opcode;
   cpuPkg::branchCode_t  branchCode;
   cpuPkg::aluFunction_t aluFn;
   logic [3:0]           statusReg;
   logic                 memOp;
   logic                 flagWrite;
   logic                 regWrite;
   logic                 useImm;
   logic                 branchTaken;

   assign opcode     = cpuPkg::opcode_t'(OpcodeCond[7:3]);
   assign branchCode = cpuPkg::branchCode_t'(OpcodeCond[2:0]);
   assign memOp      = (opcode == cpuPkg::LDW) || (opcode == cpuPkg::STW);
   assign CarryIn    = statusReg[cpuPkg::FlagC];  // For ADC and SUC

   // Instruction class decode
   always_comb begin
      aluFn     = cpuPkg::FnNop;
      flagWrite = 1'b0;
      regWrite  = 1'b0;
      useImm    = 1'b1;
      case (opcode)
         cpuPkg::ADD, cpuPkg::ADDI, cpuPkg::LDW, cpuPkg::STW, cpuPkg::JMP:
            aluFn = cpuPkg::FnAdd;
         cpuPkg::ADC: aluFn = cpuPkg::FnAdc;
         cpuPkg::SUB, cpuPkg::SUBI, cpuPkg::CMP, cpuPkg::CMPI: aluFn = cpuPkg::FnSub;
         cpuPkg::SUC: aluFn = cpuPkg::FnSuc;
         cpuPkg::LUI: aluFn = cpuPkg::FnLoadHigh;
         cpuPkg::LLI: aluFn = cpuPkg::FnLoadLow;
         default: aluFn = cpuPkg::FnNop;
      endcase
      case (opcode)
         cpuPkg::ADD, cpuPkg::ADC, cpuPkg::SUB, cpuPkg::SUC, cpuPkg::CMP: useImm = 1'b0;
         default: useImm = 1'b1;
      endcase
      // Arithmetic and compare set the flags, CMP/CMPI discard the result
      flagWrite = opcode <= cpuPkg::CMPI;
      regWrite  = (opcode <= cpuPkg::SUC) || (opcode == cpuPkg::LUI) ||
                  (opcode == cpuPkg::LLI);
   end

   always_comb begin
      case (branchCode)
         cpuPkg::BR:  branchTaken = 1'b1;
         cpuPkg::BE:  branchTaken = statusReg[cpuPkg::FlagZ];
         cpuPkg::BNE: branchTaken = !statusReg[cpuPkg::FlagZ];
         cpuPkg::BLT: branchTaken = statusReg[cpuPkg::FlagN] ^ statusReg[cpuPkg::FlagV];
         cpuPkg::BGE: branchTaken = !(statusReg[cpuPkg::FlagN] ^ statusReg[cpuPkg::FlagV]);
         default:     branchTaken = 1'b0;
      endcase
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         majorState  <= Idle;
         fetchStep   <= Fet1;
         executeStep <= Exe1;
      end else begin
         case (majorState)
            Idle: majorState <= Fetch;  // First Ale on the following cycle
            Fetch: begin
               if (fetchStep == Fet4) begin
                  majorState  <= Execute;
                  fetchStep   <= Fet1;
                  executeStep <= Exe1;
               end else begin
                  fetchStep <= fetchStep.next();
               end
            end
            default: begin
               if (!memOp || executeStep == Exe5) begin
                  majorState  <= Fetch;
                  executeStep <= Exe1;
               end else begin
                  executeStep <= executeStep.next();
               end
            end
         endcase
      end
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         statusReg <= '0;
      else if (majorState == Execute && executeStep == Exe1 && flagWrite)
         statusReg <= Flags;
   end

   always_comb begin
      Ctrl.AluOp      = cpuPkg::FnNop;
      Ctrl.Op2Sel     = cpuPkg::Op2Reg;
      Ctrl.ImmSel     = cpuPkg::ImmShort;
      Ctrl.WdSel      = cpuPkg::WdAlu;
      Ctrl.PcSel      = cpuPkg::PcNext;
      Ctrl.RegWe      = 1'b0;
      Ctrl.RdAsRa     = 1'b0;
      Ctrl.AluWe      = 1'b0;
      Ctrl.PcWe       = 1'b0;
      Ctrl.IrWe       = 1'b0;
      Ctrl.AddrFromPc = 1'b0;
      Strobes         = '{Ale: 1'b0, nMe: 1'b1, nOe: 1'b1, nWe: 1'b1,
                          BusDrive: 1'b0, Capture: 1'b0};
      if (majorState == Fetch) begin
         Strobes.nMe = 1'b0;
         case (fetchStep)
            Fet1: begin
               Strobes.Ale      = 1'b1;
               Strobes.BusDrive = 1'b1;
               Ctrl.AddrFromPc  = 1'b1;
            end
            Fet2: Strobes.nOe = 1'b0;
            Fet3: begin
               Strobes.nOe     = 1'b0;
               Strobes.Capture = 1'b1;
            end
            default: begin
               Strobes.nMe = 1'b1;
               Ctrl.IrWe   = 1'b1;
            end
         endcase
      end else if (majorState == Execute) begin
         case (executeStep)
            Exe1: begin
               Ctrl.AluOp  = aluFn;
               Ctrl.Op2Sel = useImm ? cpuPkg::Op2Imm : cpuPkg::Op2Reg;
               Ctrl.ImmSel = (opcode == cpuPkg::LUI || opcode == cpuPkg::LLI) ?
                             cpuPkg::ImmLong : cpuPkg::ImmShort;
               Ctrl.RdAsRa = opcode == cpuPkg::LUI;  // Keeps the low byte of rd
               Ctrl.RegWe  = regWrite;
               Ctrl.AluWe  = memOp;                   // Effective address
               Ctrl.PcWe   = !memOp;
               if (opcode == cpuPkg::JMP)
                  Ctrl.PcSel = cpuPkg::PcAlu;
               else if (opcode == cpuPkg::BRANCH && branchTaken)
                  Ctrl.PcSel = cpuPkg::PcBranch;
            end
            Exe2: begin
               Strobes.Ale      = 1'b1;
               Strobes.nMe      = 1'b0;
               Strobes.BusDrive = 1'b1;
            end
            Exe3: begin
               Strobes.nMe = 1'b0;
               if (opcode == cpuPkg::LDW) begin
                  Strobes.nOe = 1'b0;
               end else begin
                  Ctrl.AluOp = cpuPkg::FnPass;  // Store data into AluReg
                  Ctrl.AluWe = 1'b1;
               end
            end
            Exe4: begin
               Strobes.nMe = 1'b0;
               if (opcode == cpuPkg::LDW) begin
                  Strobes.nOe     = 1'b0;
                  Strobes.Capture = 1'b1;
               end else begin
                  Strobes.nWe      = 1'b0;
                  Strobes.BusDrive = 1'b1;
               end
            end
            default: begin
               Ctrl.PcWe  = 1'b1;
               Ctrl.RegWe = opcode == cpuPkg::LDW;
               Ctrl.WdSel = cpuPkg::WdBus;
            end
         endcase
      end
   end

endmodule

// File: source/cpuCore.sv
`timescale 1ns/10ps

module cpuCore #(
   parameter logic [cpuPkg::DataWidth-1:0] ResetVector = '0
) (
   input  logic                           Clock,
   input  logic                           nReset,
   input  logic [cpuPkg::DataWidth-1:0]   BusIn,
   output logic [cpuPkg::DataWidth-1:0]   BusOut,
   output logic                           BusDrive,
   output logic                           Ale,
   output logic                           nMe,
   output logic                           nOe,
   output logic                           nWe
);

   cpuPkg::controlWord_t         ctrl;
   cpuPkg::busStrobes_t          strobes;
   logic [7:0]                   opcodeCond;
   logic [3:0]                   flags;
   logic                         carryIn;
   logic [cpuPkg::DataWidth-1:0] instruction;
   logic [cpuPkg::DataWidth-1:0] pc;
   logic [cpuPkg::DataWidth-1:0] readA;
   logic [cpuPkg::DataWidth-1:0] readB;
   logic [cpuPkg::DataWidth-1:0] aluResult;
   logic [cpuPkg::DataWidth-1:0] aluReg;
   logic [cpuPkg::DataWidth-1:0] readData;
   logic [cpuPkg::DataWidth-1:0] writeData;

   // Load data or ALU result into rd
   assign writeData = (ctrl.WdSel == cpuPkg::WdBus) ? readData : aluResult;

   cpuControl uControl (
      .Clock(Clock), .nReset(nReset), .OpcodeCond(opcodeCond), .Flags(flags),
      .Ctrl(ctrl), .Strobes(strobes), .CarryIn(carryIn)
   );

   aluUnit uAlu (
      .Clock(Clock), .nReset(nReset), .Ctrl(ctrl), .Instruction(instruction),
      .OperandA(readA), .OperandB(readB), .CarryIn(carryIn),
      .Result(aluResult), .AluReg(aluReg), .Flags(flags)
   );

   registerFile uRegisters (
      .Clock(Clock), .nReset(nReset), .Ctrl(ctrl), .Instruction(instruction),
      .WriteData(writeData), .ReadA(readA), .ReadB(readB)
   );

   programCounter #(.ResetVector(ResetVector)) uProgramCounter (
      .Clock(Clock), .nReset(nReset), .Ctrl(ctrl), .AluResult(aluResult),
      .FetchData(readData), .Pc(pc), .Instruction(instruction), .OpcodeCond(opcodeCond)
   );

   busInterface uBus (
      .Clock(Clock), .nReset(nReset), .Ctrl(ctrl), .Strobes(strobes),
      .Pc(pc), .AluReg(aluReg), .BusIn(BusIn), .BusOut(BusOut),
      .BusDrive(BusDrive), .Ale(Ale), .nMe(nMe), .nOe(nOe), .nWe(nWe),
      .ReadData(readData)
   );

endmodule

// File: source/cpuPkg.sv
package cpuPkg;

   parameter int DataWidth = 16;

   // Status word bit positions
   localparam int FlagC = 0;
   localparam int FlagZ = 1;
   localparam int FlagN = 2;
   localparam int FlagV = 3;

   typedef enum logic [4:0] {
      ADD    = 5'd0,
      ADDI   = 5'd1,
      ADC    = 5'd2,
      SUB    = 5'd3,
      SUBI   = 5'd4,
      SUC    = 5'd5,
      CMP    = 5'd6,
      CMPI   = 5'd7,
      LUI    = 5'd8,
      LLI    = 5'd9,
      LDW    = 5'd10,
      STW    = 5'd11,
      JMP    = 5'd12,
      BRANCH = 5'd13
   } opcode_t;

   // Condition field, bits 10:8 of a BRANCH
   typedef enum logic [2:0] {
      BR  = 3'd0,
      BE  = 3'd1,
      BNE = 3'd2,
      BLT = 3'd3,
      BGE = 3'd4
   } branchCode_t;

   typedef enum logic [2:0] {
      FnNop,
      FnAdd,
      FnAdc,
      FnSub,
      FnSuc,
      FnLoadLow,
      FnLoadHigh,
      FnPass
   } aluFunction_t;

   typedef enum logic {Op2Reg, Op2Imm} op2Select_t;
   typedef enum logic {ImmShort, ImmLong} immSelect_t;
   typedef enum logic {WdAlu, WdBus} wdSelect_t;
   typedef enum logic [1:0] {PcNext, PcAlu, PcBranch} pcSelect_t;

   typedef struct packed {
      aluFunction_t AluOp;
      op2Select_t   Op2Sel;
      immSelect_t   ImmSel;
      wdSelect_t    WdSel;
      pcSelect_t    PcSel;
      logic         RegWe;
      logic         RdAsRa;      // Port A reads rd instead of ra
      logic         AluWe;
      logic         PcWe;
      logic         IrWe;
      logic         AddrFromPc;  // Fetch address
   } controlWord_t;

   typedef struct packed {
      logic Ale;
      logic nMe;
      logic nOe;
      logic nWe;
      logic BusDrive;
      logic Capture;   // Register BusIn at end of cycle
   } busStrobes_t;

endpackage

// File: source/programCounter.sv
`timescale 1ns/10ps

module programCounter #(
   parameter logic [cpuPkg::DataWidth-1:0] ResetVector = '0
) (
   input  logic                           Clock,
   input  logic                           nReset,
   input  cpuPkg::controlWord_t           Ctrl,
   input  logic [cpuPkg::DataWidth-1:0]   AluResult,
   input  logic [cpuPkg::DataWidth-1:0]   FetchData,
   output logic [cpuPkg::DataWidth-1:0]   Pc,
   output logic [cpuPkg::DataWidth-1:0]   Instruction,
   output logic [7:0]                     OpcodeCond
);

   localparam int Dw = cpuPkg::DataWidth;

   logic [Dw-1:0] pcNext;
   logic [Dw-1:0] branchTarget;

   assign pcNext       = Pc + Dw'(1);
   assign branchTarget = pcNext + {{(Dw-8){Instruction[7]}}, Instruction[7:0]};
   assign OpcodeCond   = Instruction[15:8];  // Opcode and branch condition

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         Pc          <= ResetVector;
         Instruction <= '0;
      end else begin
         if (Ctrl.PcWe) begin
            case (Ctrl.PcSel)
               cpuPkg::PcAlu:    Pc <= AluResult;
               cpuPkg::PcBranch: Pc <= branchTarget;
               default:          Pc <= pcNext;
            endcase
         end
         if (Ctrl.IrWe)
            Instruction <= FetchData;
      end
   end

endmodule

// File: source/registerFile.sv
`timescale 1ns/10ps

module registerFile (
   input  logic                           Clock,
   input  logic                           nReset,
   input  cpuPkg::controlWord_t           Ctrl,
   input  logic [cpuPkg::DataWidth-1:0]   Instruction,
   input  logic [cpuPkg::DataWidth-1:0]   WriteData,
   output logic [cpuPkg::DataWidth-1:0]   ReadA,
   output logic [cpuPkg::DataWidth-1:0]   ReadB
);

   logic [cpuPkg::DataWidth-1:0] regs [8];
   logic [2:0]                   rd;
   logic [2:0]                   addrA;
   logic [2:0]                   addrB;

   assign rd    = Instruction[10:8];
   assign addrA = Ctrl.RdAsRa ? rd : Instruction[7:5];
   assign addrB = (Ctrl.AluOp == cpuPkg::FnPass) ? rd : Instruction[4:2];  // STW data is rd
   assign ReadA = regs[addrA];
   assign ReadB = regs[addrB];

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         foreach (regs[i])
            regs[i] <= '0;
      end else if (Ctrl.RegWe) begin
         regs[rd] <= WriteData;
      end
   end

endmodule

// File: verification/busMemoryModel.sv
`timescale 1ns/10ps

module busMemoryModel (
   input  logic                         Clock,
   input  logic                         Ale,
   input  logic                         nMe,
   input  logic                         nOe,
   input  logic                         nWe,
   input  logic [cpuPkg::DataWidth-1:0] BusOut,
   output logic [cpuPkg::DataWidth-1:0] BusIn
);

   logic [cpuPkg::DataWidth-1:0] mem [256];
   logic [7:0]                   addrLatch;

   // Read data follows the latched address while nOe is low
   assign BusIn = !nOe ? mem[addrLatch] : '0;

   always @(posedge Clock) begin
      if (!nWe && !nMe)
         mem[addrLatch] = BusOut;  // Write uses the address from the Ale cycle
      if (Ale && !nMe)
         addrLatch <= BusOut[7:0];
   end

   task automatic fill();
      for (int i = 0; i < 256; i++)
         mem[i] = {8'(i) ^ 8'h5A, 8'(i)};
   endtask

   task automatic loadWord(input logic [7:0] addr, input logic [cpuPkg::DataWidth-1:0] data);
      mem[addr] = data;
   endtask

endmodule

// File: verification/cpuCoreTb.sv
`timescale 1ns/10ps

module cpuCoreTb;

   typedef logic [cpuPkg::DataWidth-1:0] word_t;

   localparam word_t ResetVector = 16'h0000;
   localparam word_t StoreAddr   = 16'h0080;

   logic  Clock;
   logic  nReset;
   word_t BusIn;
   word_t BusOut;
   logic  BusDrive;
   logic  Ale;
   logic  nMe;
   logic  nOe;
   logic  nWe;

   string                rowName[$];
   cpuPkg::opcode_t      rowOp[$];
   word_t                rowA[$];
   word_t                rowB[$];
   cpuPkg::branchCode_t  rowCond[$];
   int                   rowCount = 0;
   int unsigned          lcgState = 52;

   int    cycle;
   int    aleOp;     // Fetch of the instruction under test
   int    aleNext;   // Fetch of the one after it
   logic  writeSeen;
   logic  writeDrive;
   word_t writeAddr;
   word_t writeData;
   word_t lastAddr;

   cpuCore #(.ResetVector(ResetVector)) u_dut (
      .Clock(Clock), .nReset(nReset), .BusIn(BusIn), .BusOut(BusOut),
      .BusDrive(BusDrive), .Ale(Ale), .nMe(nMe), .nOe(nOe), .nWe(nWe)
   );

   busMemoryModel uMemory (
      .Clock(Clock), .Ale(Ale), .nMe(nMe), .nOe(nOe), .nWe(nWe),
      .BusOut(BusOut), .BusIn(BusIn)
   );

   initial begin
      Clock = 1'b0;
      forever #20 Clock = ~Clock;
   end

   // Bus observer sampled mid-cycle
   always @(negedge Clock) begin
      if (!nReset) begin
         cycle     = 0;
         aleOp     = -1;
         aleNext   = -1;
         writeSeen = 1'b0;
      end else begin
         cycle++;
         if (Ale) begin
            lastAddr = BusOut;
            if (BusOut == ResetVector + 16'd6 && aleOp < 0)
               aleOp = cycle;
            if (BusOut == ResetVector + 16'd7 && aleNext < 0)
               aleNext = cycle;
         end
         if (!nWe && !writeSeen) begin
            writeSeen  = 1'b1;
            writeAddr  = lastAddr;
            writeData  = BusOut;
            writeDrive = BusDrive;
         end
      end
   end

   function automatic word_t nextRandom();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState[30:15];
   endfunction

   function automatic word_t encReg(input cpuPkg::opcode_t op, input logic [2:0] rd,
                                    input logic [2:0] ra, input logic [2:0] rb);
      return {op, rd, ra, rb, 2'b00};
   endfunction

   function automatic word_t encShort(input cpuPkg::opcode_t op, input logic [2:0] rd,
                                      input logic [2:0] ra, input logic [4:0] imm);
      return {op, rd, ra, imm};
   endfunction

   function automatic word_t encLong(input cpuPkg::opcode_t op, input logic [2:0] rd,
                                     input logic [7:0] imm);
      return {op, rd, imm};
   endfunction

   // Reference model from the instruction rules
   function automatic word_t expectedResult(input cpuPkg::opcode_t op, input word_t a,
                                            input word_t b, input cpuPkg::branchCode_t cond);
      logic [16:0] wide;
      logic        taken;
      word_t       result;
      wide = {1'b0, a} + {1'b0, b};
      case (cond)
         cpuPkg::BE:  taken = a == b;
         cpuPkg::BNE: taken = a != b;
         cpuPkg::BLT: taken = $signed(a) < $signed(b);
         cpuPkg::BGE: taken = $signed(a) >= $signed(b);
         default:     taken = 1'b1;
      endcase
      case (op)
         cpuPkg::ADD:    result = a + b;
         cpuPkg::ADDI:   result = a + {11'd0, b[4:0]};
         cpuPkg::ADC:    result = a + b + {15'd0, wide[16]};  // Carry of the prior ADD
         cpuPkg::SUB:    result = a - b;
         cpuPkg::SUBI:   result = a - {11'd0, b[4:0]};
         cpuPkg::SUC:    result = a - b - {15'd0, !(a >= b)};  // Borrow of the prior SUB
         cpuPkg::LUI:    result = a;
         cpuPkg::LLI:    result = {8'h00, a[7:0]};
         cpuPkg::LDW:    result = a;
         cpuPkg::BRANCH: result = taken ? 16'h0022 : 16'h0011;
         cpuPkg::JMP:    result = 16'h0033;
         default:        result = '0;
      endcase
      return result;
   endfunction

   function automatic int expectedCycles(input cpuPkg::opcode_t op);
      if (op == cpuPkg::LDW)
         return 9;
      else if (op == cpuPkg::JMP)
         return 0;  // Next word is never fetched
      else
         return 5;
   endfunction

   task automatic addRow(input string name, input cpuPkg::opcode_t op, input word_t a,
                         input word_t b, input cpuPkg::branchCode_t cond);
      rowName.push_back(name);
      rowOp.push_back(op);
      rowA.push_back(a);
      rowB.push_back(b);
      rowCond.push_back(cond);
   endtask

   task automatic buildProgram(input cpuPkg::opcode_t op, input word_t a, input word_t b,
                               input cpuPkg::branchCode_t cond);
      uMemory.fill();
      uMemory.loadWord(8'd0, encLong(cpuPkg::LLI, 3'd1, a[7:0]));
      uMemory.loadWord(8'd1, encLong(cpuPkg::LUI, 3'd1, a[15:8]));
      uMemory.loadWord(8'd2, encLong(cpuPkg::LLI, 3'd2, b[7:0]));
      uMemory.loadWord(8'd3, encLong(cpuPkg::LUI, 3'd2, b[15:8]));
      uMemory.loadWord(8'd4, encLong(cpuPkg::LLI, 3'd7, StoreAddr[7:0]));
      case (op)
         cpuPkg::ADC: uMemory.loadWord(8'd5, encReg(cpuPkg::ADD, 3'd4, 3'd1, 3'd2));
         cpuPkg::SUC: uMemory.loadWord(8'd5, encReg(cpuPkg::SUB, 3'd4, 3'd1, 3'd2));
         cpuPkg::LUI: uMemory.loadWord(8'd5, encLong(cpuPkg::LLI, 3'd3, a[7:0]));
         cpuPkg::LLI: uMemory.loadWord(8'd5, encLong(cpuPkg::LUI, 3'd3, a[15:8]));
         cpuPkg::JMP: uMemory.loadWord(8'd5, encLong(cpuPkg::LLI, 3'd6, 8'd10));
         cpuPkg::LDW: begin
            uMemory.loadWord(8'd5, encLong(cpuPkg::LLI, 3'd5, 8'h40));
            uMemory.loadWord(8'h40, a);  // Word to be loaded
         end
         default: uMemory.loadWord(8'd5, encLong(cpuPkg::LLI, 3'd4, 8'd0));
      endcase
      case (op)
         cpuPkg::ADDI, cpuPkg::SUBI: uMemory.loadWord(8'd6, encShort(op, 3'd3, 3'd1, b[4:0]));
         cpuPkg::LUI:    uMemory.loadWord(8'd6, encLong(cpuPkg::LUI, 3'd3, a[15:8]));
         cpuPkg::LLI:    uMemory.loadWord(8'd6, encLong(cpuPkg::LLI, 3'd3, a[7:0]));
         cpuPkg::LDW:    uMemory.loadWord(8'd6, encShort(cpuPkg::LDW, 3'd3, 3'd5, 5'd0));
         cpuPkg::BRANCH: uMemory.loadWord(8'd6, encReg(cpuPkg::CMP, 3'd0, 3'd1, 3'd2));
         cpuPkg::JMP:    uMemory.loadWord(8'd6, encShort(cpuPkg::JMP, 3'd0, 3'd6, 5'd0));
         default:        uMemory.loadWord(8'd6, encReg(op, 3'd3, 3'd1, 3'd2));
      endcase
      case (op)
         cpuPkg::BRANCH: begin
            uMemory.loadWord(8'd7, encLong(cpuPkg::BRANCH, cond, 8'd2));  // To word 10
            uMemory.loadWord(8'd8, encLong(cpuPkg::LLI, 3'd3, 8'h11));
            uMemory.loadWord(8'd9, encLong(cpuPkg::BRANCH, cpuPkg::BR, 8'd1));
            uMemory.loadWord(8'd10, encLong(cpuPkg::LLI, 3'd3, 8'h22));
            uMemory.loadWord(8'd11, encShort(cpuPkg::STW, 3'd3, 3'd7, 5'd0));
            uMemory.loadWord(8'd12, encLong(cpuPkg::BRANCH, cpuPkg::BR, 8'hFF));
         end
         cpuPkg::JMP: begin
            uMemory.loadWord(8'd7, encLong(cpuPkg::LLI, 3'd3, 8'h11));
            uMemory.loadWord(8'd8, encShort(cpuPkg::STW, 3'd3, 3'd7, 5'd0));
            uMemory.loadWord(8'd9, encLong(cpuPkg::BRANCH, cpuPkg::BR, 8'hFF));
            uMemory.loadWord(8'd10, encLong(cpuPkg::LLI, 3'd3, 8'h33));
            uMemory.loadWord(8'd11, encShort(cpuPkg::STW, 3'd3, 3'd7, 5'd0));
            uMemory.loadWord(8'd12, encLong(cpuPkg::BRANCH, cpuPkg::BR, 8'hFF));
         end
         default: begin
            uMemory.loadWord(8'd7, encShort(cpuPkg::STW, 3'd3, 3'd7, 5'd0));
            uMemory.loadWord(8'd8, encLong(cpuPkg::BRANCH, cpuPkg::BR, 8'hFF));  // Halt
         end
      endcase
   endtask

   task automatic checkWord(input string name, input word_t expected, input word_t actual);
      if (expected !== actual) begin
         $display("FAIL %s expected %h actual %h", name, expected, actual);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic checkCount(input string name, input int expected, input int actual);
      if (expected != actual) begin
         $display("FAIL %s expected %0d actual %0d", name, expected, actual);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic checkLevel(input string name, input logic expected, input logic actual);
      if (expected !== actual) begin
         $display("FAIL %s expected %b actual %b", name, expected, actual);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic resetCore(input int row);
      nReset = 1'b0;
      buildProgram(rowOp[row], rowA[row], rowB[row], rowCond[row]);
      repeat (4) @(posedge Clock);
      #2;
      checkLevel({rowName[row], " reset Ale"}, 1'b0, Ale);
      checkLevel({rowName[row], " reset BusDrive"}, 1'b0, BusDrive);
      checkLevel({rowName[row], " reset nMe"}, 1'b1, nMe);
      checkLevel({rowName[row], " reset nOe"}, 1'b1, nOe);
      checkLevel({rowName[row], " reset nWe"}, 1'b1, nWe);
      nReset = 1'b1;
      @(posedge Clock);
      #2;
      checkLevel({rowName[row], " first Ale"}, 1'b1, Ale);
      checkLevel({rowName[row], " first BusDrive"}, 1'b1, BusDrive);
      checkWord({rowName[row], " first address"}, ResetVector, BusOut);
   endtask

   initial begin
      nReset = 1'b0;
      addRow("add_random", cpuPkg::ADD, nextRandom(), nextRandom(), cpuPkg::BR);
      addRow("add_wrap", cpuPkg::ADD, 16'hFFFF, 16'h0001, cpuPkg::BR);
      addRow("adc_random", cpuPkg::ADC, nextRandom(), nextRandom(), cpuPkg::BR);
      addRow("adc_carry", cpuPkg::ADC, 16'h8000, 16'h8001, cpuPkg::BR);
      addRow("sub_random", cpuPkg::SUB, nextRandom(), nextRandom(), cpuPkg::BR);
      addRow("suc_borrow", cpuPkg::SUC, 16'h0001, 16'h0002, cpuPkg::BR);
      addRow("suc_random", cpuPkg::SUC, nextRandom(), nextRandom(), cpuPkg::BR);
      addRow("addi_random", cpuPkg::ADDI, nextRandom(), nextRandom(), cpuPkg::BR);
      addRow("subi_wrap", cpuPkg::SUBI, 16'h0003, 16'h0005, cpuPkg::BR);
      addRow("lui_const", cpuPkg::LUI, 16'hBEEF, 16'h0000, cpuPkg::BR);
      addRow("lli_const", cpuPkg::LLI, 16'h12F4, 16'h0000, cpuPkg::BR);
      addRow("ldw_word", cpuPkg::LDW, 16'hCAFE, 16'h0000, cpuPkg::BR);
      addRow("be_equal", cpuPkg::BRANCH, 16'h0005, 16'h0005, cpuPkg::BE);
      addRow("be_unequal", cpuPkg::BRANCH, 16'h0005, 16'h0006, cpuPkg::BE);
      addRow("bne_random", cpuPkg::BRANCH, nextRandom(), nextRandom(), cpuPkg::BNE);
      addRow("blt_signed", cpuPkg::BRANCH, 16'h8000, 16'h0001, cpuPkg::BLT);
      addRow("bge_overflow", cpuPkg::BRANCH, 16'h7FFF, 16'h8000, cpuPkg::BGE);
      addRow("jmp_reg", cpuPkg::JMP, 16'h0000, 16'h0000, cpuPkg::BR);
      rowCount = rowName.size();
      @(posedge Clock);
      #2;
      for (int i = 0; i < rowCount; i++) begin
         resetCore(i);
         for (int n = 0; n < 100 && !writeSeen; n++)
            @(posedge Clock);
         #2;
         if (!writeSeen) begin
            $display("Row %s never wrote its result to memory", rowName[i]);
            $display("Simulation failed");
            $fatal(1);
         end
         checkWord({rowName[i], " address"}, StoreAddr, writeAddr);
         checkLevel({rowName[i], " write BusDrive"}, 1'b1, writeDrive);
         checkWord({rowName[i], " data"}, expectedResult(rowOp[i], rowA[i], rowB[i],
                   rowCond[i]), writeData);
         if (expectedCycles(rowOp[i]) != 0)
            checkCount({rowName[i], " cycles"}, expectedCycles(rowOp[i]), aleNext - aleOp);
      end
      $display("Simulation completed successfully");
      $finish;
   end

   // Generous bound on reset plus the longest program per row
   initial begin
      wait (rowCount > 0);
      repeat (rowCount * 110 + 20) @(posedge Clock);
      $display("Watchdog expired before all rows finished");
      $display("Simulation failed");
      $fatal(1);
   end

endmodule
